// File: verilog.f
source/game_state_pkg.sv
source/stage_map_pkg.sv
source/stage_controller.sv
source/game_controller.sv
source/wave_tracker.sv
source/game_flow_top.sv
tests/game_flow_props.sv
tests/game_flow_tb.sv

// File: Bender.yml
package:
  name: game_flow

sources:
  # packages first
  - source/game_state_pkg.sv
  - source/stage_map_pkg.sv
  # RTL
  - source/stage_controller.sv
  - source/game_controller.sv
  - source/wave_tracker.sv
  - source/game_flow_top.sv
  # testbench
  - target: test
    files:
      - tests/game_flow_props.sv
      - tests/game_flow_tb.sv

// File: tests/game_flow_tb.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// game flow testbench
// random hits, pause, skip, death and win checked
// against a model of the stage tables
//////////////////////////////////////////////////

module game_flow_tb;

    import game_state_pkg::*;
    import stage_map_pkg::*;

    localparam int WAIT_STAGE = 0;  // wait selectors
    localparam int WAIT_RUN   = 1;
    localparam int WAIT_IDLE  = 2;
    localparam int WAIT_WON   = 3;
    localparam int WAIT_OVER  = 4;
    localparam int WAIT_RESET = 5;

    logic clk, resetN, start_game, pause, skip_stage, player_dead;
    logic monst_hit, astero_hit, boss_hit;
    logic game_won, game_over, enable_player, enable_monst, enable_astero, enable_boss;
    logic resetN_player, resetN_monst, resetN_astero, resetN_boss;
    logic [STAGE_W-1:0] stage_num;

    integer seed = 9383;
    int errors = 0;
    int timeouts = 0;
    int kills;                  // model kill count in the current stage
    logic [STAGE_W-1:0] cur;    // model stage
    logic [STAGE_W-1:0] watch;  // stage seen before a wait

    game_flow_top u_game_flow_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic logic condition_met(input int sel);
        case (sel)
            WAIT_STAGE: return (stage_num != watch) || game_won;
            WAIT_RUN:   return enable_player;
            WAIT_IDLE:  return !enable_player;
            WAIT_WON:   return game_won;
            WAIT_OVER:  return game_over;
            default:    return !resetN_player && (stage_num == FIRST_STAGE) && !game_won;
        endcase
    endfunction

    task automatic wait_for(input int sel, input string what);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!condition_met(sel) && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        if (!condition_met(sel)) begin
            $display("timeout while waiting for %s", what);
            timeouts++;
        end
    endtask

    // enables and enemy resets in RUN follow the stage table
    task automatic check_stage_enables(input logic [STAGE_W-1:0] s);
        if (stage_num != s) report_error($sformatf("stage %0d, expected %0d", stage_num, s));
        if (enable_monst !== STAGE_MONST[s-1]) report_error("enable_monst against table");
        if (enable_astero !== STAGE_ASTERO[s-1]) report_error("enable_astero against table");
        if (enable_boss !== STAGE_BOSS[s-1]) report_error("enable_boss against table");
        if (!enable_player) report_error("enable_player low in run");
        if (resetN_player !== 1'b1) report_error("player held in reset in run");
        if (resetN_monst !== STAGE_MONST[s-1]) report_error("resetN_monst against table");
        if (resetN_astero !== STAGE_ASTERO[s-1]) report_error("resetN_astero against table");
        if (resetN_boss !== STAGE_BOSS[s-1]) report_error("resetN_boss against table");
        if (game_won || game_over) report_error("flags set in run");
    endtask

    task automatic check_reset_outputs();
        if (game_won || game_over || enable_player) report_error("flags not clear in reset");
        if (enable_monst || enable_astero || enable_boss) report_error("enables high in reset");
        if (resetN_player || resetN_monst || resetN_astero || resetN_boss)
            report_error("block resets released in reset");
        if (stage_num != FIRST_STAGE) report_error("stage not 1 in reset");
    endtask

    // random strobes until the model count reaches target
    task automatic hit_until(input int target);
        logic [2:0] r;
        while (kills < target) begin
            @(posedge clk);
            r = $random(seed);
            monst_hit  <= r[0];
            astero_hit <= r[1];
            boss_hit   <= r[2];
            kills += int'(r[0] & STAGE_MONST[cur-1]) + int'(r[1] & STAGE_ASTERO[cur-1])
                   + int'(r[2] & STAGE_BOSS[cur-1]);
            @(negedge clk);
            if (stage_num != cur) report_error("stage advanced before quota");
        end
        @(posedge clk);
        {monst_hit, astero_hit, boss_hit} <= 3'b000;
    endtask

    task automatic clear_stage();
        hit_until(int'(STAGE_QUOTA[cur-1]));
        watch = cur;
        wait_for(WAIT_STAGE, "stage change after quota");
        if (cur != LAST_STAGE) begin
            if (resetN_monst) report_error("monster reset not pulsed on stage change");
            cur = cur + 1'b1;
            @(negedge clk);
            check_stage_enables(cur);
        end
        kills = 0;
    endtask

    // skip held for many cycles, one advance only
    task automatic skip_held();
        @(posedge clk);
        skip_stage <= 1'b1;
        watch = cur;
        wait_for(WAIT_STAGE, "stage change after skip");
        if (cur != LAST_STAGE) cur = cur + 1'b1;
        repeat (12) begin
            @(negedge clk);
            if (stage_num != cur) report_error("held skip advanced more than once");
        end
        @(posedge clk);
        skip_stage <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic restart();
        @(posedge clk);
        start_game <= 1'b0;
        wait_for(WAIT_RESET, "reset state");
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        start_game <= 1'b1;
        wait_for(WAIT_RUN, "run after start");
        cur   = FIRST_STAGE;
        kills = 0;
        @(negedge clk);
        check_stage_enables(cur);
    endtask

    initial begin
        resetN = 1'b0;
        start_game = 1'b0;
        pause = 1'b0;
        skip_stage = 1'b0;
        player_dead = 1'b0;
        monst_hit = 1'b0;
        astero_hit = 1'b0;
        boss_hit = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_reset_outputs();
        @(posedge clk);
        resetN <= 1'b1;
        restart();
        clear_stage();  // stage 1
        clear_stage();  // stage 2
        hit_until(3);   // part of stage 3, then pause
        @(posedge clk);
        pause <= 1'b1;
        wait_for(WAIT_IDLE, "pause");
        repeat (10) begin
            @(posedge clk);
            {monst_hit, astero_hit, boss_hit} <= 3'($random(seed));
            @(negedge clk);
            if (enable_monst || enable_astero || enable_boss) report_error("enable in pause");
        end
        @(posedge clk);
        {monst_hit, astero_hit, boss_hit} <= 3'b000;
        pause <= 1'b0;
        wait_for(WAIT_RUN, "release of pause");
        clear_stage();  // rest of stage 3
        skip_held();    // stage 4 to 5
        clear_stage();  // boss hits win the game
        wait_for(WAIT_WON, "game won");
        @(negedge clk);
        if (!game_won || game_over) report_error("won game flags");
        if (enable_monst || enable_astero || enable_boss) report_error("enables after win");
        restart();
        repeat (5) skip_held();
        if (!game_won || game_over) report_error("skip on last stage did not win");
        restart();
        @(posedge clk);
        player_dead <= 1'b1;
        wait_for(WAIT_OVER, "game over");
        @(negedge clk);
        if (enable_monst || enable_astero || enable_boss || enable_player)
            report_error("enables after death");
        if (resetN_monst || resetN_astero || resetN_boss) report_error("enemies not in reset");
        @(posedge clk);
        player_dead <= 1'b0;
        restart();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tests/game_flow_props.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// game controller properties
// flag, enable, stage range and state checks
//////////////////////////////////////////////////

module game_flow_props (
    input logic                               clk,
    input logic                               resetN,
    input game_state_pkg::flow_state_t        state,
    input logic                               game_won,
    input logic                               game_over,
    input logic                               enable_monst,
    input logic                               enable_astero,
    input logic                               enable_boss,
    input logic [game_state_pkg::STAGE_W-1:0] stage_num
);

    import game_state_pkg::*;

    logic any_enable;
    assign any_enable = enable_monst | enable_astero | enable_boss;

    won_not_over: assert property (@(posedge clk) disable iff (!resetN)
        !(game_won && game_over)) else $error("game_won and game_over together");

    idle_no_enable: assert property (@(posedge clk) disable iff (!resetN)
        (state == PAUSE || state == RESET) |-> !any_enable) else $error("enable while idle");

    stage_in_range: assert property (@(posedge clk) disable iff (!resetN)
        stage_num >= FIRST_STAGE && stage_num <= LAST_STAGE) else $error("stage out of range");

    won_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
        state == STAGE_WON |=> state != STAGE_WON) else $error("STAGE_WON held two cycles");

endmodule

bind game_controller game_flow_props u_game_flow_props (
    .clk(clk), .resetN(resetN), .state(state), .game_won(game_won), .game_over(game_over),
    .enable_monst(enable_monst), .enable_astero(enable_astero), .enable_boss(enable_boss),
    .stage_num(stage_num)
);

// File: source/game_flow_top.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// game flow top
// game controller and wave tracker joined to the
// board switches and the enemy hit strobes
//////////////////////////////////////////////////

module game_flow_top (
    input  logic                               clk,
    input  logic                               resetN,
    input  logic                               start_game,
    input  logic                               pause,
    input  logic                               skip_stage,
    input  logic                               player_dead,
    input  logic                               monst_hit,
    input  logic                               astero_hit,
    input  logic                               boss_hit,
    output logic                               game_won,
    output logic                               game_over,
    output logic                               enable_player,
    output logic                               enable_monst,
    output logic                               enable_astero,
    output logic                               enable_boss,
    output logic                               resetN_player,
    output logic                               resetN_monst,
    output logic                               resetN_astero,
    output logic                               resetN_boss,
    output logic [game_state_pkg::STAGE_W-1:0] stage_num
);

    logic win_stage;  // quota reached, back to the controller

    game_controller u_game_controller (
        .clk           (clk),
        .resetN        (resetN),
        .start_game    (start_game),
        .pause         (pause),
        .skip_stage    (skip_stage),
        .player_dead   (player_dead),
        .win_stage     (win_stage),
        .game_won      (game_won),
        .game_over     (game_over),
        .enable_player (enable_player),
        .enable_monst  (enable_monst),
        .enable_astero (enable_astero),
        .enable_boss   (enable_boss),
        .resetN_player (resetN_player),
        .resetN_monst  (resetN_monst),
        .resetN_astero (resetN_astero),
        .resetN_boss   (resetN_boss),
        .stage_num     (stage_num)
    );

    wave_tracker u_wave_tracker (
        .clk           (clk),
        .resetN        (resetN),
        .monst_hit     (monst_hit),
        .astero_hit    (astero_hit),
        .boss_hit      (boss_hit),
        .enable_monst  (enable_monst),
        .enable_astero (enable_astero),
        .enable_boss   (enable_boss),
        .resetN_player (resetN_player),
        .stage_num     (stage_num),
        .win_stage     (win_stage)
    );

endmodule

// File: source/wave_tracker.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// wave tracker
// counts hits on active enemies and pulses a
// stage win when the kill quota is reached
//////////////////////////////////////////////////

module wave_tracker (
    input  logic                               clk,
    input  logic                               resetN,
    input  logic                               monst_hit,      // one cycle strobes
    input  logic                               astero_hit,
    input  logic                               boss_hit,
    input  logic                               enable_monst,
    input  logic                               enable_astero,
    input  logic                               enable_boss,
    input  logic                               resetN_player,  // clears the count
    input  logic [game_state_pkg::STAGE_W-1:0] stage_num,
    output logic                               win_stage
);

    import game_state_pkg::*;
    import stage_map_pkg::*;

    logic [1:0]         hit_cnt;     // counted hits this cycle
    logic [QUOTA_W:0]   kill_sum;    // one spare bit for saturation
    logic [QUOTA_W-1:0] kill_cnt;
    logic [QUOTA_W-1:0] quota;
    logic [STAGE_W-1:0] stage_idx;
    logic [STAGE_W-1:0] prev_stage;
    logic               clear_cnt;
    logic               reported;    // win already sent this stage

    // a hit counts only while its kind is enabled
    assign hit_cnt = {1'b0, monst_hit & enable_monst}
                   + {1'b0, astero_hit & enable_astero}
                   + {1'b0, boss_hit & enable_boss};

    assign kill_sum  = {1'b0, kill_cnt} + {{(QUOTA_W-1){1'b0}}, hit_cnt};
    assign stage_idx = stage_num - FIRST_STAGE;
    assign quota     = STAGE_QUOTA[stage_idx];
    assign clear_cnt = ~resetN_player | (stage_num != prev_stage);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            prev_stage <= FIRST_STAGE;
            kill_cnt   <= '0;
        end else begin
            prev_stage <= stage_num;
            if (clear_cnt) begin
                kill_cnt <= '0;
            end else if (kill_sum[QUOTA_W]) begin
                kill_cnt <= '1;  // saturate
            end else begin
                kill_cnt <= kill_sum[QUOTA_W-1:0];
            end
        end
    end

    // single registered pulse per stage
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            win_stage <= 1'b0;
            reported  <= 1'b0;
        end else if (clear_cnt) begin
            win_stage <= 1'b0;
            reported  <= 1'b0;
        end else if (!reported && (kill_cnt >= quota)) begin
            win_stage <= 1'b1;
            reported  <= 1'b1;
        end else begin
            win_stage <= 1'b0;
        end
    end

endmodule

// File: source/game_controller.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// game controller
// flow state machine of the game: reset, run,
// pause, stage won and game over
//////////////////////////////////////////////////

module game_controller (
    input  logic                               clk,
    input  logic                               resetN,
    input  logic                               start_game,   // board switch
    input  logic                               pause,        // board switch
    input  logic                               skip_stage,   // command, rising edge counts
    input  logic                               player_dead,
    input  logic                               win_stage,    // from the wave tracker
    output logic                               game_won,
    output logic                               game_over,
    output logic                               enable_player,
    output logic                               enable_monst,
    output logic                               enable_astero,
    output logic                               enable_boss,
    output logic                               resetN_player,
    output logic                               resetN_monst,
    output logic                               resetN_astero,
    output logic                               resetN_boss,
    output logic [game_state_pkg::STAGE_W-1:0] stage_num
);

    import game_state_pkg::*;

    flow_state_t state;
    flow_state_t next_state;

    logic start_sync;     // registered switches
    logic pause_sync;
    logic skip_d;
    logic skip_pulse;     // rising edge of skip_stage
    logic stage_advance;  // taken only when moving to STAGE_WON
    logic hold_player;    // state wants the block in reset
    logic hold_monst;
    logic hold_astero;
    logic hold_boss;
    logic run_enable_monst;
    logic run_enable_astero;
    logic run_enable_boss;

    // one register stage on the switches
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            start_sync <= 1'b0;
            pause_sync <= 1'b0;
            skip_d     <= 1'b0;
        end else begin
            start_sync <= start_game;
            pause_sync <= pause;
            skip_d     <= skip_stage;
        end
    end

    assign skip_pulse = skip_stage & ~skip_d;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state    = state;
        stage_advance = 1'b0;
        enable_player = 1'b1;
        game_over     = 1'b0;
        hold_player   = 1'b0;
        hold_monst    = 1'b0;
        hold_astero   = 1'b0;
        hold_boss     = 1'b0;
        case (state)
            RESET: begin
                enable_player = 1'b0;
                hold_player   = 1'b1;
                hold_monst    = 1'b1;
                hold_astero   = 1'b1;
                hold_boss     = 1'b1;
                if (start_sync) begin
                    next_state = RUN;
                end
            end
            RUN: begin
                if (!start_sync) begin
                    next_state = RESET;
                end else if (pause_sync) begin
                    next_state = PAUSE;
                end else if (player_dead) begin
                    next_state = GAME_OVER;
                end else if (win_stage || skip_pulse) begin
                    next_state    = STAGE_WON;
                    stage_advance = 1'b1;
                end
            end
            PAUSE: begin
                enable_player = 1'b0;  // freeze everything
                if (!start_sync) begin
                    next_state = RESET;
                end else if (!pause_sync) begin
                    next_state = RUN;
                end
            end
            STAGE_WON: begin
                hold_monst = 1'b1;  // fresh monster wave
                if (!start_sync) begin
                    next_state = RESET;
                end else if (game_won) begin
                    next_state = GAME_OVER;
                end else begin
                    next_state = RUN;
                end
            end
            GAME_OVER: begin
                game_over     = ~game_won;  // lost, not won
                enable_player = 1'b0;
                hold_monst    = 1'b1;
                hold_astero   = 1'b1;
                hold_boss     = 1'b1;
                if (!start_sync) begin
                    next_state = RESET;
                end
            end
            default: begin
                next_state = RESET;
            end
        endcase
    end

    stage_controller u_stage_controller (
        .clk               (clk),
        .resetN            (resetN),
        .start_level       (start_sync),
        .stage_advance     (stage_advance),
        .stage_num         (stage_num),
        .game_won          (game_won),
        .run_enable_monst  (run_enable_monst),
        .run_enable_astero (run_enable_astero),
        .run_enable_boss   (run_enable_boss)
    );

    // inactive kinds are both disabled and held in reset
    assign enable_monst  = enable_player & run_enable_monst;
    assign enable_astero = enable_player & run_enable_astero;
    assign enable_boss   = enable_player & run_enable_boss;
    assign resetN_player = ~hold_player;
    assign resetN_monst  = ~hold_monst & run_enable_monst;
    assign resetN_astero = ~hold_astero & run_enable_astero;
    assign resetN_boss   = ~hold_boss & run_enable_boss;

endmodule

// File: source/stage_controller.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////
// stage controller
// counts stages 1 to 5, flags the won game and
// enables the enemy kinds of the current stage
//////////////////////////////////////////////////

module stage_controller (
    input  logic                               clk,
    input  logic                               resetN,
    input  logic                               start_level,    // sampled start switch
    input  logic                               stage_advance,  // one cycle pulse
    output logic [game_state_pkg::STAGE_W-1:0] stage_num,
    output logic                               game_won,
    output logic                               run_enable_monst,
    output logic                               run_enable_astero,
    output logic                               run_enable_boss
);

    import game_state_pkg::*;
    import stage_map_pkg::*;

    logic [STAGE_W-1:0] stage_idx;  // zero based table index

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            stage_num <= FIRST_STAGE;
            game_won  <= 1'b0;
        end else if (!start_level) begin
            stage_num <= FIRST_STAGE;  // back to the first stage
            game_won  <= 1'b0;
        end else if (stage_advance && !game_won) begin
            if (stage_num == LAST_STAGE) begin
                game_won <= 1'b1;  // cleared the last stage
            end else begin
                stage_num <= stage_num + 1'b1;
            end
        end
    end

    assign stage_idx = stage_num - FIRST_STAGE;

    // table lookup, everything stops once the game is won
    assign run_enable_monst  = STAGE_MONST[stage_idx] & ~game_won;
    assign run_enable_astero = STAGE_ASTERO[stage_idx] & ~game_won;
    assign run_enable_boss   = STAGE_BOSS[stage_idx] & ~game_won;

endmodule

// File: source/stage_map_pkg.sv
//////////////////////////////////////////////////
// stage map
// which enemy kinds appear in each stage and how
// many kills clear it
//////////////////////////////////////////////////

package stage_map_pkg;

    localparam int NUM_STAGES = 5;

    // bit i-1 set means the kind is active in stage i
    localparam logic [NUM_STAGES-1:0] STAGE_MONST  = 5'b01011;  // stages 1, 2, 4
    localparam logic [NUM_STAGES-1:0] STAGE_ASTERO = 5'b01100;  // stages 3, 4
    localparam logic [NUM_STAGES-1:0] STAGE_BOSS   = 5'b10000;  // last stage only

    localparam int QUOTA_W = 4;  // width of a kill count

    // kills needed per stage, entry 0 is stage 1
    localparam logic [NUM_STAGES-1:0][QUOTA_W-1:0] STAGE_QUOTA = {
        4'd3,  // stage 5, boss
        4'd8,  // stage 4
        4'd5,  // stage 3
        4'd6,  // stage 2
        4'd4   // stage 1
    };

endpackage

// File: source/game_state_pkg.sv
//////////////////////////////////////////////////
// game state definitions
// flow states and stage numbering shared by the
// game and stage controllers
//////////////////////////////////////////////////

package game_state_pkg;

    // high level flow of the game
    typedef enum logic [2:0] {
        RESET     = 3'd0,  // all blocks held in reset
        RUN       = 3'd1,
        PAUSE     = 3'd2,  // everything frozen
        STAGE_WON = 3'd3,  // one cycle between stages
        GAME_OVER = 3'd4
    } flow_state_t;

    localparam int STAGE_W = 3;  // width of stage_num

    // stages are numbered from one
    localparam logic [STAGE_W-1:0] FIRST_STAGE = 3'd1;
    localparam logic [STAGE_W-1:0] LAST_STAGE  = 3'd5;

endpackage
